//--- src.f
+incdir+verilog
verilog/ldpc_enc_pkg.sv
verilog/ldpc_enc_cycle_if.sv
verilog/ldpc_enc_hs.sv
verilog/ldpc_enc_ctrl.sv
verilog/ldpc_enc_parity.sv
verilog/ldpc_enc_top.sv
testbench/tb_clk_gen.sv
testbench/ldpc_enc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build the ldpc encoder testbench with Verilator and run it
# the log decides pass or fail

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -f src.f --top-module ldpc_enc_tb -o ldpc_enc_sim \
  && ./obj_dir/ldpc_enc_sim > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -q "^Test OK$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- testbench/ldpc_enc_tb.sv
// --------------------------------------------------------------------------
// ldpc encoder testbench
// directed tests per code rate, staircase parity model from the Hs tables,
// back-to-back encodes and clock enable stalls
// --------------------------------------------------------------------------

`timescale 1ns/1ps

`include "ldpc_enc_consts.svh"

module ldpc_enc_tb import ldpc_enc_pkg::*; ();

  `include "ldpc_enc_hs_tab.svh"

  localparam int cPIPE     = 1;
  localparam int cCLK_NS   = 40;
  localparam int cSEED     = 10;
  localparam int cNUM_RUNS = 15;
  localparam int cLOOP_MAX = 100;

  localparam coderate_t cRATES [3] = '{cRATE_1BY2, cRATE_2BY3, cRATE_3BY4};

  logic      iclk;
  logic      ireset;
  logic      iclkena;
  code_ctx_t icode_ctx;
  logic      iwrite;
  dat_t      iwdat;
  logic      istart;
  col_t      oused_data_col;
  row_t      oused_row;
  logic      obusy;
  logic      oval;
  dat_t      odat;
  logic      oeop;

  int   errors;
  int   first_lat;
  dat_t wdata [`LDPC_MAX_COL];
  dat_t exp_par [$];
  dat_t got_par [$];
  bit   got_eop [$];
  dat_t ref_par [$];

  tb_clk_gen #(
    .pPERIOD     (cCLK_NS),
    .pRST_CYCLES (5)
  ) clk_gen_i (
    .clk (iclk),
    .rst (ireset)
  );

  ldpc_enc_top #(
    .pPIPE (cPIPE)
  ) ldpc_enc_top_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .iclkena        (iclkena),
    .icode_ctx      (icode_ctx),
    .iwrite         (iwrite),
    .iwdat          (iwdat),
    .istart         (istart),
    .oused_data_col (oused_data_col),
    .oused_row      (oused_row),
    .obusy          (obusy),
    .oval           (oval),
    .odat           (odat),
    .oeop           (oeop)
  );

  // --------------------------------------------------------------------------
  // reference model
  // --------------------------------------------------------------------------

  // code sizes per rate
  function automatic col_t exp_cols(coderate_t rate);
    case (rate)
      cRATE_1BY2 : return col_t'(4);
      cRATE_2BY3 : return col_t'(4);
      default    : return col_t'(6);
    endcase
  endfunction

  function automatic row_t exp_rows(coderate_t rate);
    case (rate)
      cRATE_1BY2 : return row_t'(4);
      cRATE_2BY3 : return row_t'(2);
      default    : return row_t'(2);
    endcase
  endfunction

  function automatic int tab_size(coderate_t rate);
    case (rate)
      cRATE_1BY2 : return cRATE_1BY2_TAB_SIZE;
      cRATE_2BY3 : return cRATE_2BY3_TAB_SIZE;
      default    : return cRATE_3BY4_TAB_SIZE;
    endcase
  endfunction

  function automatic cycle_ctx_t tab_entry(coderate_t rate, int k);
    case (rate)
      cRATE_1BY2 : return cRATE_1BY2_TAB[k];
      cRATE_2BY3 : return cRATE_2BY3_TAB[k];
      default    : return cRATE_3BY4_TAB[k];
    endcase
  endfunction

  // entries up to and including the first eop
  function automatic int first_row_len(coderate_t rate);
    cycle_ctx_t e;
    for (int k = 0; k < tab_size(rate); k++) begin
      e = tab_entry(rate, k);
      if (e.eop) begin
        return k + 1;
      end
    end
    return tab_size(rate);
  endfunction

  // bit i lands on bit (i + s) mod Z
  function automatic dat_t rotate_left(dat_t d, shift_t s);
    dat_t r;
    for (int i = 0; i < `LDPC_Z; i++) begin
      r[(i + int'(s)) % `LDPC_Z] = d[i];
    end
    return r;
  endfunction

  // row syndromes folded into the staircase
  task automatic model_parity(input coderate_t rate);
    cycle_ctx_t e;
    dat_t       syn;
    dat_t       par;
    exp_par.delete();
    syn = '0;
    par = '0;
    for (int k = 0; k < tab_size(rate); k++) begin
      e   = tab_entry(rate, k);
      syn = syn ^ rotate_left(wdata[e.col_idx], e.shift);
      if (e.eop) begin
        par = par ^ syn;
        exp_par.push_back(par);
        syn = '0;
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // compare tasks
  // --------------------------------------------------------------------------

  task automatic check_dat(input string name, input dat_t exp, input dat_t act);
    if (exp !== act) begin
      errors++;
      $display("** Error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_dims(input string name, input col_t exp_col, input row_t exp_row,
                            input col_t act_col, input row_t act_row);
    if (exp_col !== act_col || exp_row !== act_row) begin
      errors++;
      $display("** Error: %s expected cols/rows %0d/%0d actual %0d/%0d",
               name, exp_col, exp_row, act_col, act_row);
    end
  endtask

  task automatic check_parity(input string name);
    if (got_par.size() != exp_par.size()) begin
      errors++;
      $display("%s: %0d parity words came out, %0d were expected",
               name, got_par.size(), exp_par.size());
    end
    for (int r = 0; r < got_par.size() && r < exp_par.size(); r++) begin
      check_dat($sformatf("%s row %0d", name, r), exp_par[r], got_par[r]);
      if (got_eop[r] != (r == exp_par.size() - 1)) begin
        errors++;
        $display("%s: oeop is wrong on row %0d", name, r);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // stimulus
  // --------------------------------------------------------------------------

  task automatic fill_random();
    for (int c = 0; c < `LDPC_MAX_COL; c++) begin
      wdata[c] = dat_t'($urandom);
    end
  endtask

  // column load and start then parity words up to oeop
  task automatic encode(input string name, input coderate_t rate, input bit stall);
    int cyc;
    int n;
    int stall_left;
    bit ena_edge;
    bit done;
    got_par.delete();
    got_eop.delete();
    stall_left = 0;
    done       = 1'b0;
    cyc        = 0;
    @(posedge iclk);
    icode_ctx <= '{coderate: rate};
    iclkena   <= 1'b1;
    for (int c = 0; c < int'(exp_cols(rate)); c++) begin
      @(posedge iclk);
      iwrite <= 1'b1;
      iwdat  <= wdata[c];
    end
    @(posedge iclk);
    iwrite <= 1'b0;
    istart <= 1'b1;
    while (!done) begin
      @(posedge iclk);
      // enable as seen by the DUT on this edge
      ena_edge = iclkena;
      istart <= 1'b0;
      cyc++;
      // first stretch lands while table reads are in flight
      if (stall && stall_left == 0 && (cyc == 2 || $urandom_range(0, 3) == 0)) begin
        stall_left = $urandom_range(1, 3);
      end
      if (stall_left > 0) begin
        iclkena <= 1'b0;
        stall_left--;
      end
      else begin
        iclkena <= 1'b1;
      end
      @(negedge iclk);
      if (cyc == 1 && !obusy) begin
        errors++;
        $display("%s: obusy did not rise after istart", name);
      end
      if (ena_edge && oval) begin
        if (got_par.size() == 0) begin
          first_lat = cyc;
        end
        got_par.push_back(odat);
        got_eop.push_back(oeop);
        if (!obusy) begin
          errors++;
          $display("%s: obusy was low while a parity word was out", name);
        end
        if (oeop || got_par.size() >= int'(exp_rows(rate))) begin
          done = 1'b1;
        end
      end
      if (!done && cyc >= cLOOP_MAX) begin
        errors++;
        $display("%s: the last parity word did not come within %0d cycles", name, cLOOP_MAX);
        done = 1'b1;
      end
    end
    // busy should drop together with the last word
    n = 0;
    do begin
      @(posedge iclk);
      ena_edge = iclkena;
      iclkena <= 1'b1;
      @(negedge iclk);
      n++;
      if (ena_edge && oval) begin
        errors++;
        $display("%s: a parity word came after the last row", name);
      end
    end while (obusy && n < 8);
    if (obusy) begin
      errors++;
      $display("%s: obusy stayed high after the encode", name);
    end
    else if (!stall && n != 1) begin
      errors++;
      $display("%s: obusy did not fall with the last parity word", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic test_idle();
    for (int i = 0; i < 10; i++) begin
      @(negedge iclk);
      if (oval || oeop || obusy) begin
        errors++;
        $display("test_idle: outputs active before any start");
      end
    end
  endtask

  task automatic test_dims();
    foreach (cRATES[i]) begin
      @(posedge iclk);
      icode_ctx <= '{coderate: cRATES[i]};
      @(negedge iclk);
      check_dims($sformatf("test_dims rate %0d", i), exp_cols(cRATES[i]),
                 exp_rows(cRATES[i]), oused_data_col, oused_row);
    end
  endtask

  task automatic test_rates();
    string name;
    int    exp_lat;
    foreach (cRATES[i]) begin
      name = $sformatf("test_rates rate %0d", i);
      fill_random();
      encode(name, cRATES[i], 1'b0);
      model_parity(cRATES[i]);
      check_parity(name);
      exp_lat = 1 + first_row_len(cRATES[i]) - 1 + cPIPE + 2;
      if (got_par.size() > 0 && first_lat != exp_lat) begin
        errors++;
        $display("%s: first parity word after %0d cycles, %0d expected",
                 name, first_lat, exp_lat);
      end
    end
  endtask

  // rate changes between runs without a reset
  task automatic test_back_to_back();
    coderate_t seq [4];
    string     name;
    seq = '{cRATE_3BY4, cRATE_1BY2, cRATE_2BY3, cRATE_1BY2};
    foreach (seq[i]) begin
      name = $sformatf("test_back_to_back run %0d", i);
      fill_random();
      encode(name, seq[i], 1'b0);
      model_parity(seq[i]);
      check_parity(name);
    end
  endtask

  // same data with and without iclkena stalls
  task automatic test_stall();
    string name;
    foreach (cRATES[i]) begin
      name = $sformatf("test_stall rate %0d", i);
      fill_random();
      encode(name, cRATES[i], 1'b0);
      ref_par = got_par;
      encode(name, cRATES[i], 1'b1);
      model_parity(cRATES[i]);
      check_parity(name);
      for (int r = 0; r < got_par.size() && r < ref_par.size(); r++) begin
        check_dat($sformatf("%s stalled row %0d", name, r), ref_par[r], got_par[r]);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // main sequence and watchdog
  // --------------------------------------------------------------------------

  initial begin
    errors    = 0;
    first_lat = 0;
    iclkena   = 1'b1;
    icode_ctx = '{coderate: cRATE_1BY2};
    iwrite    = 1'b0;
    iwdat     = '0;
    istart    = 1'b0;
    void'($urandom(cSEED));
    @(negedge ireset);
    test_idle();
    test_dims();
    test_rates();
    test_back_to_back();
    test_stall();
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("Test OK");
    end
    else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(cNUM_RUNS * (`LDPC_MAX_CYCLE + 40) * cCLK_NS);
    $display("watchdog expired before the tests finished, errors so far: %0d", errors);
    $display("Test FAILED");
    $finish;
  end

endmodule

//--- testbench/tb_clk_gen.sv
// --------------------------------------------------------------------------
// testbench clock and reset
// free running clock, reset held high for the first few rising edges
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int pPERIOD     = 40,
  parameter int pRST_CYCLES = 5
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(pPERIOD / 2) clk = ~clk;
  end

  // release on a rising edge, as a registered reset would
  initial begin
    rst = 1'b1;
    repeat (pRST_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

//--- verilog/ldpc_enc_top.sv
// --------------------------------------------------------------------------
// ldpc encoder top level
// sequencer, Hs table ROM and parity unit
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldpc_enc_top import ldpc_enc_pkg::*; #(
  parameter int pPIPE = 1
) (
  input  logic      iclk,
  input  logic      ireset,
  input  logic      iclkena,
  input  code_ctx_t icode_ctx,
  input  logic      iwrite,
  input  dat_t      iwdat,
  input  logic      istart,
  output col_t      oused_data_col,
  output row_t      oused_row,
  output logic      obusy,
  output logic      oval,
  output dat_t      odat,
  output logic      oeop
);

  logic       cycle_read;
  cycle_idx_t cycle_idx;
  cycle_idx_t cycle_max_num;

  ldpc_enc_cycle_if cyc ();

  // table walk
  ldpc_enc_ctrl #(
    .pPIPE (pPIPE)
  ) ctrl_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .iclkena        (iclkena),
    .istart         (istart),
    .icycle_max_num (cycle_max_num),
    .ocycle_read    (cycle_read),
    .ocycle_idx     (cycle_idx),
    .obusy          (obusy)
  );

  ldpc_enc_hs #(
    .pPIPE (pPIPE)
  ) hs_i (
    .iclk           (iclk),
    .ireset         (ireset),
    .iclkena        (iclkena),
    .icode_ctx      (icode_ctx),
    .oused_data_col (oused_data_col),
    .oused_row      (oused_row),
    .ocycle_max_num (cycle_max_num),
    .icycle_read    (cycle_read),
    .icycle_idx     (cycle_idx),
    .cyc            (cyc.src)
  );

  // parity words out
  ldpc_enc_parity parity_i (
    .iclk      (iclk),
    .ireset    (ireset),
    .iclkena   (iclkena),
    .istart    (istart),
    .iwrite    (iwrite),
    .iwdat     (iwdat),
    .iused_row (oused_row),
    .cyc       (cyc.dst),
    .oval      (oval),
    .odat      (odat),
    .oeop      (oeop)
  );

endmodule

//--- verilog/ldpc_enc_parity.sv
// --------------------------------------------------------------------------
// ldpc encoder parity unit
// column buffer, circulant rotation, row syndrome accumulation and
// staircase parity output
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldpc_enc_parity import ldpc_enc_pkg::*; (
  input  logic iclk,
  input  logic ireset,
  input  logic iclkena,
  input  logic istart,
  input  logic iwrite,
  input  dat_t iwdat,
  input  row_t iused_row,
  ldpc_enc_cycle_if.dst cyc,
  output logic oval,
  output dat_t odat,
  output logic oeop
);

  `include "ldpc_enc_consts.svh"

  dat_t col_buf [`LDPC_MAX_COL];
  col_t waddr;
  logic enc_act;
  logic row_end;
  dat_t acc;
  dat_t prev_par;
  dat_t acc_nxt;
  dat_t par_nxt;
  row_t row_cnt;

  // --------------------------------------------------------------------------
  // column buffer
  // --------------------------------------------------------------------------

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      waddr   <= '0;
      enc_act <= 1'b0;
    end
    else if (iclkena) begin
      if (istart) begin
        waddr <= '0;
      end
      else if (iwrite && !enc_act) begin
        waddr <= waddr + col_t'(1);
      end
      // encode window ends with the last parity word
      if (istart) begin
        enc_act <= 1'b1;
      end
      else if (oval && oeop) begin
        enc_act <= 1'b0;
      end
    end
  end

  always_ff @(posedge iclk) begin
    if (iclkena && iwrite && !enc_act) begin
      col_buf[waddr] <= iwdat;
    end
  end

  // --------------------------------------------------------------------------
  // rotation and row accumulation
  // --------------------------------------------------------------------------

  // bit i goes to bit (i + s) mod Z
  function automatic dat_t rotl(dat_t d, shift_t s);
    logic [2 * `LDPC_Z - 1 : 0] w;
    w = {d, d} << s;
    return w[2 * `LDPC_Z - 1 -: `LDPC_Z];
  endfunction

  assign row_end = cyc.read & cyc.strb.eop;
  assign acc_nxt = acc ^ rotl(col_buf[cyc.col_idx], cyc.shift);
  // staircase, p(r) = p(r-1) ^ s(r)
  assign par_nxt = prev_par ^ acc_nxt;

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (istart) begin
        acc      <= '0;
        prev_par <= '0;
      end
      else if (row_end) begin
        acc      <= '0;
        prev_par <= par_nxt;
        odat     <= par_nxt;
      end
      else if (cyc.read) begin
        acc <= acc_nxt;
      end
    end
  end

  // row count and output strobes
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      row_cnt <= '0;
      oval    <= 1'b0;
      oeop    <= 1'b0;
    end
    else if (iclkena) begin
      oval <= row_end;
      oeop <= row_end && (row_cnt == iused_row - row_t'(1));
      if (istart) begin
        row_cnt <= '0;
      end
      else if (row_end) begin
        row_cnt <= row_cnt + row_t'(1);
      end
    end
  end

  // buffer must not change under a running encode
  assert property (@(posedge iclk) disable iff (ireset) enc_act |-> !iwrite);

endmodule

//--- verilog/ldpc_enc_ctrl.sv
// --------------------------------------------------------------------------
// ldpc encoder sequencer
// walks the Hs table one entry per clock and holds busy until the
// last parity word leaves the pipeline
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldpc_enc_ctrl import ldpc_enc_pkg::*; #(
  parameter int pPIPE = 1
) (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  logic       istart,
  input  cycle_idx_t icycle_max_num,
  output logic       ocycle_read,
  output cycle_idx_t ocycle_idx,
  output logic       obusy
);

  // rom latency plus the parity output register
  localparam logic [1:0] cDRAIN = 2'(pPIPE + 2);

  logic [1:0] drain_cnt;

  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      ocycle_read <= 1'b0;
      ocycle_idx  <= '0;
      drain_cnt   <= '0;
    end
    else if (iclkena) begin
      if (istart) begin
        ocycle_read <= 1'b1;
        ocycle_idx  <= '0;
      end
      else if (ocycle_read) begin
        // last entry, hand over to drain
        if (ocycle_idx == icycle_max_num - cycle_idx_t'(1)) begin
          ocycle_read <= 1'b0;
          drain_cnt   <= cDRAIN;
        end
        else begin
          ocycle_idx <= ocycle_idx + cycle_idx_t'(1);
        end
      end
      else if (drain_cnt != '0) begin
        drain_cnt <= drain_cnt - 2'd1;
      end
    end
  end

  // busy while reading or draining
  assign obusy = ocycle_read | (drain_cnt != '0);

  // no restart of a running encode
  assert property (@(posedge iclk) disable iff (ireset) !(istart && obusy));

endmodule

//--- verilog/ldpc_enc_hs.sv
// --------------------------------------------------------------------------
// ldpc encoder Hs table ROM
// code context selects the table, read latency is pPIPE + 1 clocks,
// code constants come straight from the code rate
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module ldpc_enc_hs import ldpc_enc_pkg::*; #(
  parameter int pPIPE = 1
) (
  input  logic       iclk,
  input  logic       ireset,
  input  logic       iclkena,
  input  code_ctx_t  icode_ctx,
  output col_t       oused_data_col,
  output row_t       oused_row,
  output cycle_idx_t ocycle_max_num,
  input  logic       icycle_read,
  input  cycle_idx_t icycle_idx,
  ldpc_enc_cycle_if.src cyc
);

  `include "ldpc_enc_consts.svh"
  `include "ldpc_enc_hs_tab.svh"

  localparam int cIDX_W = $clog2(`LDPC_MAX_CYCLE);

  // --------------------------------------------------------------------------
  // code constants
  // --------------------------------------------------------------------------

  assign oused_data_col = get_used_data_col(icode_ctx);
  assign oused_row      = get_used_row(icode_ctx);
  assign ocycle_max_num = get_used_cycle_num(icode_ctx);

  // --------------------------------------------------------------------------
  // table read
  // --------------------------------------------------------------------------

  logic [1:0] rd_dly;
  cycle_ctx_t rdat [2];

  // read flag delay line
  always_ff @(posedge iclk or posedge ireset) begin
    if (ireset) begin
      rd_dly <= '0;
    end
    else if (iclkena) begin
      rd_dly <= {rd_dly[0], icycle_read};
    end
  end

  // entry registered, then one optional stage
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      case (icode_ctx.coderate)
        cRATE_1BY2 : rdat[0] <= cRATE_1BY2_TAB[icycle_idx[cIDX_W - 1 : 0]];
        cRATE_2BY3 : rdat[0] <= cRATE_2BY3_TAB[icycle_idx[cIDX_W - 1 : 0]];
        default    : rdat[0] <= cRATE_3BY4_TAB[icycle_idx[cIDX_W - 1 : 0]];
      endcase
      rdat[1] <= rdat[0];
    end
  end

  // tap picked by pipeline depth
  assign cyc.read     = rd_dly[pPIPE];
  assign cyc.strb.eop = rdat[pPIPE].eop;
  assign cyc.col_idx  = rdat[pPIPE].col_idx;
  assign cyc.shift    = rdat[pPIPE].shift;

  // sequencer must stay inside the selected table
  assert property (@(posedge iclk) disable iff (ireset)
    icycle_read |-> (icycle_idx < ocycle_max_num));

  // --------------------------------------------------------------------------
  // rate decode
  // --------------------------------------------------------------------------

  function automatic col_t get_used_data_col(code_ctx_t code_ctx);
    case (code_ctx.coderate)
      cRATE_3BY4 : return col_t'(6);
      default    : return col_t'(4);
    endcase
  endfunction

  function automatic row_t get_used_row(code_ctx_t code_ctx);
    case (code_ctx.coderate)
      cRATE_1BY2 : return row_t'(4);
      default    : return row_t'(2);
    endcase
  endfunction

  function automatic cycle_idx_t get_used_cycle_num(code_ctx_t code_ctx);
    case (code_ctx.coderate)
      cRATE_1BY2 : return cycle_idx_t'(cRATE_1BY2_TAB_SIZE);
      cRATE_2BY3 : return cycle_idx_t'(cRATE_2BY3_TAB_SIZE);
      default    : return cycle_idx_t'(cRATE_3BY4_TAB_SIZE);
    endcase
  endfunction

endmodule

//--- verilog/ldpc_enc_cycle_if.sv
// --------------------------------------------------------------------------
// Hs cycle entry link
// one table entry per read pulse, from the ROM to the parity unit
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface ldpc_enc_cycle_if import ldpc_enc_pkg::*; ();

  // one cycle valid, no back-pressure
  logic   read;
  strb_t  strb;
  col_t   col_idx;
  shift_t shift;

  modport src (output read, output strb, output col_idx, output shift);
  modport dst (input  read, input  strb, input  col_idx, input  shift);

endinterface

//--- verilog/ldpc_enc_pkg.sv
// --------------------------------------------------------------------------
// ldpc encoder types
// code context, table indexes and the Hs cycle entry layout
// --------------------------------------------------------------------------

package ldpc_enc_pkg;

  `include "ldpc_enc_consts.svh"

  // toy code rates
  typedef enum logic [1:0] {
    cRATE_1BY2 = 2'd0,
    cRATE_2BY3 = 2'd1,
    cRATE_3BY4 = 2'd2
  } coderate_t;

  typedef struct packed {
    coderate_t coderate;
  } code_ctx_t;

  // column index, also holds the column count
  typedef logic [$clog2(`LDPC_MAX_COL + 1) - 1 : 0]   col_t;
  typedef logic [$clog2(`LDPC_MAX_ROW + 1) - 1 : 0]   row_t;
  typedef logic [$clog2(`LDPC_Z) - 1 : 0]             shift_t;
  // entry index, also holds the entry count
  typedef logic [$clog2(`LDPC_MAX_CYCLE + 1) - 1 : 0] cycle_idx_t;

  // one circulant word
  typedef logic [`LDPC_Z - 1 : 0] dat_t;

  // only end of row is left
  typedef struct packed {
    logic eop;
  } strb_t;

  // one Hs table entry
  typedef struct packed {
    logic   eop;
    col_t   col_idx;
    shift_t shift;
  } cycle_ctx_t;

endpackage

//--- verilog/ldpc_enc_consts.svh
// --------------------------------------------------------------------------
// ldpc encoder sizes
// circulant width and the limits of the Hs table and the column buffer
// --------------------------------------------------------------------------

`ifndef LDPC_ENC_CONSTS_SVH
`define LDPC_ENC_CONSTS_SVH

// circulant size in bits
`define LDPC_Z          8

// largest code over all rates
`define LDPC_MAX_COL    6
`define LDPC_MAX_ROW    4

// table depth, every rate fits in here
`define LDPC_MAX_CYCLE  16

`endif

//--- verilog/ldpc_enc_hs_tab.svh
// --------------------------------------------------------------------------
// ldpc encoder Hs cycle tables
// entries row by row as {eop, col_idx, shift}, eop closes a row
// --------------------------------------------------------------------------

// rate 1/2, 4 data columns, 4 rows
localparam int cRATE_1BY2_TAB_SIZE = 8;

localparam cycle_ctx_t cRATE_1BY2_TAB [`LDPC_MAX_CYCLE] = '{
  0       : '{1'b0, 3'd0, 3'd1},
  1       : '{1'b1, 3'd2, 3'd5},
  2       : '{1'b0, 3'd1, 3'd3},
  3       : '{1'b1, 3'd3, 3'd0},
  4       : '{1'b0, 3'd0, 3'd6},
  5       : '{1'b0, 3'd1, 3'd2},
  6       : '{1'b1, 3'd3, 3'd4},
  7       : '{1'b1, 3'd2, 3'd7},
  default : '0
};

// rate 2/3, 4 data columns, 2 rows
localparam int cRATE_2BY3_TAB_SIZE = 6;

localparam cycle_ctx_t cRATE_2BY3_TAB [`LDPC_MAX_CYCLE] = '{
  0       : '{1'b0, 3'd0, 3'd2},
  1       : '{1'b0, 3'd1, 3'd4},
  2       : '{1'b1, 3'd3, 3'd1},
  3       : '{1'b0, 3'd0, 3'd5},
  4       : '{1'b0, 3'd2, 3'd3},
  5       : '{1'b1, 3'd3, 3'd6},
  default : '0
};

// rate 3/4, 6 data columns, 2 rows
localparam int cRATE_3BY4_TAB_SIZE = 8;

localparam cycle_ctx_t cRATE_3BY4_TAB [`LDPC_MAX_CYCLE] = '{
  0       : '{1'b0, 3'd0, 3'd1},
  1       : '{1'b0, 3'd1, 3'd7},
  2       : '{1'b0, 3'd2, 3'd3},
  3       : '{1'b1, 3'd4, 3'd5},
  4       : '{1'b0, 3'd1, 3'd2},
  5       : '{1'b0, 3'd3, 3'd0},
  6       : '{1'b0, 3'd4, 3'd6},
  7       : '{1'b1, 3'd5, 3'd4},
  default : '0
};
